/* Bender.yml */
package:
  name: fcal

export_include_dirs:
  - include

sources:
  - rtl/fcal_pkg.sv
  - rtl/fcal_sync.sv
  - rtl/fcal_ref_pulse_gen.sv
  - rtl/fcal_counter.sv
  - rtl/fcal_result_track.sv
  - rtl/fcal_axil_regs.sv
  - rtl/fcal_top.sv
  - target: test
    files:
      - dv/fcal_tb.sv

/* dv/fcal_tb.sv */
`timescale 1ns/1ns
`include "fcal_macros.svh"

module fcal_tb;

	import fcal_pkg::*;

	localparam int T_FB = 20; // clk_fb period, ns
	localparam int T_REF = 30; // clk_refp period, ns
	localparam int HS_MAX = 20; // cycles per channel handshake
	localparam int POLL_MAX = 400; // STATUS reads per poll
	localparam int SETTLE = 12; // pulse reselect after an ndiv write

	logic clk_fb;
	logic clk_refp;
	logic rst;
	axil_req_t req;
	axil_rsp_t rsp;
	logic [15:0] lfsr;

	// model of the tracker
	fcal_cnt_t model_last;
	fcal_cnt_t model_min;
	fcal_cnt_t model_max;
	fcal_num_t model_num;
	fcal_ndiv_t ndiv_q[$]; // pending results for the compare process
	fcal_cnt_t last_q[$];

	fcal_top UUT (
		.clk_fb(clk_fb),
		.clk_refp(clk_refp),
		.rst(rst),
		.axil_req(req),
		.axil_rsp(rsp)
	);

	always #(T_FB / 2) clk_fb = ~clk_fb;
	always #(T_REF / 2) clk_refp = ~clk_refp;

	// ------------------------------
	// reference and random source
	// ------------------------------
	// pulse high time over the fb period
	function automatic fcal_cnt_t expected_count(input fcal_ndiv_t nd);
		return fcal_cnt_t'(((1 << nd) * T_REF) / T_FB);
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic pick_ndiv(output fcal_ndiv_t nd);
		logic [2:0] v;
		v = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = {v[1:0], lfsr[0]};
		end
		nd = fcal_ndiv_t'(2 + v % 5); // 2..6
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_cnt(input string name, input fcal_cnt_t got, input fcal_cnt_t exp,
		input int tol);
		int diff;
		diff = int'(got) - int'(exp);
		if ($isunknown(got) || diff > tol || diff < -tol)
			stop_on_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_num(input string name, input fcal_num_t got, input fcal_num_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// compare each read-back LAST, then advance the model
	always @(posedge clk_fb) begin : compare_results
		fcal_ndiv_t nd;
		fcal_cnt_t got;
		if (last_q.size() != 0) begin
			nd = ndiv_q.pop_front();
			got = last_q.pop_front();
			check_cnt("LAST", got, expected_count(nd), 2); // +-2 cycles of sync jitter
			model_last = got;
			if (got < model_min)
				model_min = got;
			if (got > model_max)
				model_max = got;
			if (model_num != 8'hFF)
				model_num = model_num + 1'b1;
		end
	end

	// ------------------------------
	// AXI4-Lite driver, negedge side
	// ------------------------------
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		output logic [1:0] resp);
		int t;
		t = 0;
		@(negedge clk_fb);
		req.awaddr = addr;
		req.wdata = data;
		req.awvalid = 1'b1;
		req.wvalid = 1'b1;
		while (!(rsp.awready && rsp.wready)) begin
			@(negedge clk_fb);
			t++;
			if (t > HS_MAX)
				stop_on_error("timeout waiting for awready and wready");
		end
		@(negedge clk_fb); // accepted on the edge just past
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		req.bready = 1'b1;
		t = 0;
		while (!rsp.bvalid) begin
			@(negedge clk_fb);
			t++;
			if (t > HS_MAX)
				stop_on_error("timeout waiting for bvalid");
		end
		resp = rsp.bresp;
		@(negedge clk_fb);
		req.bready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output logic [1:0] resp);
		int t;
		t = 0;
		@(negedge clk_fb);
		req.araddr = addr;
		req.arvalid = 1'b1;
		while (!rsp.arready) begin
			@(negedge clk_fb);
			t++;
			if (t > HS_MAX)
				stop_on_error("timeout waiting for arready");
		end
		@(negedge clk_fb);
		req.arvalid = 1'b0;
		req.rready = 1'b1;
		t = 0;
		while (!rsp.rvalid) begin
			@(negedge clk_fb);
			t++;
			if (t > HS_MAX)
				stop_on_error("timeout waiting for rvalid");
		end
		data = rsp.rdata;
		resp = rsp.rresp;
		@(negedge clk_fb);
		req.rready = 1'b0;
	endtask

	task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_resp("BRESP", resp, 2'b00);
	endtask

	task automatic read_ok(input axil_addr_t addr, output axil_data_t data);
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_resp("RRESP", resp, 2'b00);
	endtask

	// poll STATUS ready until it reaches level
	task automatic wait_status(input logic level);
		axil_data_t d;
		int n;
		n = 0;
		read_ok(`FCAL_REG_STATUS, d);
		while (d[0] !== level) begin
			n++;
			if (n > POLL_MAX)
				stop_on_error("STATUS ready never reached the expected level");
			read_ok(`FCAL_REG_STATUS, d);
		end
	endtask

	// one full start/ready cycle, then start or en withdrawn
	task automatic measure(input fcal_ndiv_t nd, input logic drop_en);
		axil_data_t d;
		write_ok(`FCAL_REG_NDIV, axil_data_t'(nd));
		repeat (SETTLE) @(negedge clk_fb); // partial pulse from the bit switch
		write_ok(`FCAL_REG_CTRL, 32'h3); // en and start
		wait_status(1'b1);
		read_ok(`FCAL_REG_LAST, d);
		ndiv_q.push_back(nd);
		last_q.push_back(fcal_cnt_t'(d));
		write_ok(`FCAL_REG_CTRL, drop_en ? 32'h2 : 32'h1);
		wait_status(1'b0); // ready falls with the request
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		axil_data_t d;
		fcal_ndiv_t nd;
		logic [1:0] resp;
		clk_fb = 1'b0;
		clk_refp = 1'b0;
		rst = 1'b1;
		req = '0;
		lfsr = 16'd49947;
		model_last = '0;
		model_min = '1;
		model_max = '0;
		model_num = '0;
		repeat (4) @(negedge clk_fb);
		rst = 1'b0;

		// state after reset
		read_ok(`FCAL_REG_STATUS, d);
		check_num("STATUS", fcal_num_t'(d), 8'h00);
		read_ok(`FCAL_REG_NUM, d);
		check_num("NUM", fcal_num_t'(d), model_num);
		read_ok(`FCAL_REG_MIN, d);
		check_cnt("MIN", fcal_cnt_t'(d), model_min, 0);

		// single measurement
		measure(4'd4, 1'b0);
		read_ok(`FCAL_REG_NUM, d);
		check_num("NUM", fcal_num_t'(d), 8'd1);

		// random ndiv runs, last one drops en instead of start
		for (int i = 0; i < 5; i++) begin
			pick_ndiv(nd);
			measure(nd, i == 4);
			read_ok(`FCAL_REG_MIN, d);
			check_cnt("MIN", fcal_cnt_t'(d), model_min, 0);
			read_ok(`FCAL_REG_MAX, d);
			check_cnt("MAX", fcal_cnt_t'(d), model_max, 0);
			read_ok(`FCAL_REG_NUM, d);
			check_num("NUM", fcal_num_t'(d), model_num);
		end

		// clear through CTRL bit 2
		write_ok(`FCAL_REG_CTRL, 32'h4);
		model_last = '0;
		model_min = '1;
		model_max = '0;
		model_num = '0;
		read_ok(`FCAL_REG_NUM, d);
		check_num("NUM", fcal_num_t'(d), model_num);
		read_ok(`FCAL_REG_MAX, d);
		check_cnt("MAX", fcal_cnt_t'(d), model_max, 0);
		read_ok(`FCAL_REG_MIN, d);
		check_cnt("MIN", fcal_cnt_t'(d), model_min, 0);
		read_ok(`FCAL_REG_LAST, d);
		check_cnt("LAST", fcal_cnt_t'(d), model_last, 0);

		// decode error, and a write to a read-only register
		axil_read(8'h40, d, resp);
		check_resp("RRESP", resp, 2'b10);
		write_ok(`FCAL_REG_STATUS, 32'h1);

		$display("TEST PASS");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
rtl/fcal_pkg.sv
rtl/fcal_sync.sv
rtl/fcal_ref_pulse_gen.sv
rtl/fcal_counter.sv
rtl/fcal_result_track.sv
rtl/fcal_axil_regs.sv
rtl/fcal_top.sv
dv/fcal_tb.sv

/* include/fcal_macros.svh */
`ifndef FCAL_MACROS_SVH
`define FCAL_MACROS_SVH

// ------------------------------
// widths
// ------------------------------
`define FCAL_N_CNT      12 // feedback count width
`define FCAL_SYNC_DEPTH 3  // pulse sync stages into clk_fb
`define FCAL_AXIL_AW    8
`define FCAL_AXIL_DW    32

// ------------------------------
// register map, byte offsets
// ------------------------------
`define FCAL_REG_CTRL   8'h00 // en, start, clear
`define FCAL_REG_NDIV   8'h04
`define FCAL_REG_STATUS 8'h08 // ready
`define FCAL_REG_LAST   8'h0C
`define FCAL_REG_MIN    8'h10
`define FCAL_REG_MAX    8'h14
`define FCAL_REG_NUM    8'h18

`endif

/* rtl/fcal_axil_regs.sv */
`timescale 1ns/1ns
`include "fcal_macros.svh"

module fcal_axil_regs (
	input logic clk_fb,
	input logic rst,
	input fcal_pkg::axil_req_t axil_req,
	output fcal_pkg::axil_rsp_t axil_rsp,
	output fcal_pkg::fcal_ctrl_t ctrl,
	output logic clear, // self-clearing CTRL bit 2
	input logic fcal_ready,
	input fcal_pkg::fcal_stats_t stats
);

	import fcal_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic aw_take; // start a write accept
	logic ar_take;
	logic wr_fire; // aw/w handshake this cycle
	logic rd_fire;
	axil_data_t rd_mux;

	// true for any offset in the map, read-only ones included
	function automatic logic reg_hit(input axil_addr_t addr);
		case (addr)
			`FCAL_REG_CTRL, `FCAL_REG_NDIV, `FCAL_REG_STATUS, `FCAL_REG_LAST,
			`FCAL_REG_MIN, `FCAL_REG_MAX, `FCAL_REG_NUM: reg_hit = 1'b1;
			default: reg_hit = 1'b0;
		endcase
	endfunction

	assign aw_take = axil_req.awvalid & axil_req.wvalid & ~axil_rsp.awready & ~axil_rsp.bvalid;
	assign ar_take = axil_req.arvalid & ~axil_rsp.arready & ~axil_rsp.rvalid;
	assign wr_fire = axil_rsp.awready & axil_req.awvalid & axil_req.wvalid;
	assign rd_fire = axil_rsp.arready & axil_req.arvalid;

	// read mux, sampled at rd_fire
	always_comb begin
		rd_mux = '0;
		case (axil_req.araddr)
			`FCAL_REG_CTRL: rd_mux = axil_data_t'({ctrl.start, ctrl.en}); // clear reads 0
			`FCAL_REG_NDIV: rd_mux = axil_data_t'(ctrl.ndiv);
			`FCAL_REG_STATUS: rd_mux = axil_data_t'(fcal_ready);
			`FCAL_REG_LAST: rd_mux = axil_data_t'(stats.last);
			`FCAL_REG_MIN: rd_mux = axil_data_t'(stats.min);
			`FCAL_REG_MAX: rd_mux = axil_data_t'(stats.max);
			`FCAL_REG_NUM: rd_mux = axil_data_t'(stats.num);
			default: rd_mux = '0;
		endcase
	end

	// ------------------------------
	// channel control and registers
	// ------------------------------
	always_ff @(posedge clk_fb) begin
		if (rst) begin
			axil_rsp.awready <= 1'b0;
			axil_rsp.wready <= 1'b0;
			axil_rsp.bvalid <= 1'b0;
			axil_rsp.arready <= 1'b0;
			axil_rsp.rvalid <= 1'b0;
			ctrl <= '0;
			clear <= 1'b0;
		end else begin
			clear <= 1'b0; // pulse only
			axil_rsp.awready <= aw_take; // aw and w ready together
			axil_rsp.wready <= aw_take;
			if (wr_fire) begin
				axil_rsp.bvalid <= 1'b1;
				if (axil_req.awaddr == `FCAL_REG_CTRL) begin
					ctrl.en <= axil_req.wdata[0];
					ctrl.start <= axil_req.wdata[1];
					clear <= axil_req.wdata[2];
				end
				if (axil_req.awaddr == `FCAL_REG_NDIV)
					ctrl.ndiv <= axil_req.wdata[$bits(fcal_ndiv_t)-1:0];
			end else if (axil_req.bready) begin
				axil_rsp.bvalid <= 1'b0;
			end
			axil_rsp.arready <= ar_take;
			if (rd_fire)
				axil_rsp.rvalid <= 1'b1;
			else if (axil_req.rready)
				axil_rsp.rvalid <= 1'b0;
		end
	end

	// response payload, only looked at while valid
	always_ff @(posedge clk_fb) begin
		if (wr_fire)
			axil_rsp.bresp <= reg_hit(axil_req.awaddr) ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			axil_rsp.rdata <= rd_mux;
			axil_rsp.rresp <= reg_hit(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// response and its code held until the host takes them
	a_bvalid_hold: assert property (
		@(posedge clk_fb) disable iff (rst)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp)
	);

endmodule

/* rtl/fcal_counter.sv */
`timescale 1ns/1ns
`include "fcal_macros.svh"

module fcal_counter (
	input logic clk_fb,
	input logic rst,
	input fcal_pkg::fcal_ctrl_t ctrl,
	input logic [`FCAL_SYNC_DEPTH-1:0] pulse_d, // synced ref pulse, all stages
	output fcal_pkg::fcal_cnt_t fcal_cnt, // latched result
	output logic fcal_ready // ack for ctrl.start
);

	import fcal_pkg::*;

	localparam int D = `FCAL_SYNC_DEPTH;

	fcal_state_e state;
	fcal_cnt_t fb_cnt; // running count in pulse window
	logic armed;
	logic pulse_rise;
	logic pulse_fall;

	assign armed = ctrl.en & ctrl.start;
	// edges on the two oldest stages only
	assign pulse_rise = (pulse_d[D-1:D-2] == 2'b01);
	assign pulse_fall = (pulse_d[D-1:D-2] == 2'b10);

	// ------------------------------
	// fsm and handshake
	// ------------------------------
	always_ff @(posedge clk_fb) begin
		if (rst) begin
			state <= IDLE;
			fcal_ready <= 1'b0;
		end else if (!armed) begin
			state <= IDLE; // request withdrawn
			fcal_ready <= 1'b0; // drops one cycle later
		end else begin
			case (state)
				IDLE: state <= WAIT_RISE;
				WAIT_RISE: if (pulse_rise) state <= COUNT;
				COUNT: begin
					if (pulse_fall) begin
						state <= DONE;
						fcal_ready <= 1'b1;
					end
				end
				DONE: fcal_ready <= 1'b1; // hold until start or en drops
				default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------
	// count datapath
	// ------------------------------
	always_ff @(posedge clk_fb) begin
		if (state == WAIT_RISE && pulse_rise)
			fb_cnt <= '0; // window opens
		else if (state == COUNT)
			fb_cnt <= fb_cnt + 1'b1;
		if (state == COUNT && pulse_fall && armed)
			fcal_cnt <= fb_cnt + 1'b1; // include the fall cycle
	end

	a_ready_needs_start: assert property (
		@(posedge clk_fb) disable iff (rst)
		$rose(fcal_ready) |-> ctrl.start
	);

	// ndiv too large for the clk ratio would overflow the count
	a_no_wrap: assert property (
		@(posedge clk_fb) disable iff (rst)
		state == COUNT |-> fb_cnt != '1
	);

endmodule

/* rtl/fcal_pkg.sv */
`include "fcal_macros.svh"

package fcal_pkg;

	// ------------------------------
	// plain vector types
	// ------------------------------
	typedef logic [`FCAL_N_CNT-1:0] fcal_cnt_t; // one count word
	typedef logic [$clog2(`FCAL_N_CNT)-1:0] fcal_ndiv_t; // refp divide exponent
	typedef logic [7:0] fcal_num_t; // measurement number, saturating
	typedef logic [`FCAL_AXIL_DW-1:0] axil_data_t;
	typedef logic [`FCAL_AXIL_AW-1:0] axil_addr_t;

	// host to slave
	typedef struct packed {
		axil_addr_t awaddr;
		logic awvalid;
		axil_data_t wdata;
		logic wvalid;
		logic bready;
		axil_addr_t araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// slave to host
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		axil_data_t rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic en; // calibration enable
		logic start; // request, held until ready
		fcal_ndiv_t ndiv;
	} fcal_ctrl_t;

	typedef struct packed {
		fcal_cnt_t last;
		fcal_cnt_t min;
		fcal_cnt_t max;
		fcal_num_t num;
	} fcal_stats_t;

	typedef enum logic [1:0] {IDLE, WAIT_RISE, COUNT, DONE} fcal_state_e;

endpackage

/* rtl/fcal_ref_pulse_gen.sv */
`timescale 1ns/1ns
`include "fcal_macros.svh"

module fcal_ref_pulse_gen (
	input logic clk_refp,
	input logic rst_ref, // already synced to clk_refp
	input fcal_pkg::fcal_ndiv_t ndiv,
	output logic ref_pulse
);

	import fcal_pkg::*;

	fcal_cnt_t ref_cnt; // free-running refp counter

	// bit ndiv toggles every 2^ndiv refp cycles
	always_ff @(posedge clk_refp) begin
		if (rst_ref) begin
			ref_cnt <= '0;
			ref_pulse <= 1'b0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			ref_pulse <= ref_cnt[ndiv]; // registered, no mux glitch
		end
	end

	// ndiv comes from the clk_fb register block and must index a real bit
	a_ndiv_range: assert property (
		@(posedge clk_refp) disable iff (rst_ref !== 1'b0)
		ndiv < `FCAL_N_CNT
	);

endmodule

/* rtl/fcal_result_track.sv */
`timescale 1ns/1ns

module fcal_result_track (
	input logic clk_fb,
	input logic rst,
	input logic fcal_ready,
	input fcal_pkg::fcal_cnt_t fcal_cnt,
	input logic clear, // one-cycle pulse from regs
	output fcal_pkg::fcal_stats_t stats
);

	import fcal_pkg::*;

	localparam fcal_num_t NUM_MAX = '1; // saturate at 255

	logic ready_q;
	logic ready_rise; // one new result

	assign ready_rise = fcal_ready & ~ready_q;

	always_ff @(posedge clk_fb) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= fcal_ready;
	end

	// running stats, clear restarts min/max window
	always_ff @(posedge clk_fb) begin
		if (rst || clear) begin
			stats.last <= '0;
			stats.min <= '1; // any result beats it
			stats.max <= '0;
			stats.num <= '0;
		end else if (ready_rise) begin
			stats.last <= fcal_cnt;
			if (fcal_cnt < stats.min)
				stats.min <= fcal_cnt;
			if (fcal_cnt > stats.max)
				stats.max <= fcal_cnt;
			if (stats.num != NUM_MAX)
				stats.num <= stats.num + 1'b1;
		end
	end

endmodule

/* rtl/fcal_sync.sv */
`timescale 1ns/1ns

// plain flop chain, no reset so it can carry the reset itself
module fcal_sync #(
	parameter int DEPTH = 2 // two or more
) (
	input logic clk,
	input logic din,
	output logic dout,
	output logic [DEPTH-1:0] din_d // [0] newest, [DEPTH-1] oldest
);

	always_ff @(posedge clk) begin
		din_d <= {din_d[DEPTH-2:0], din}; // shift toward msb
	end

	assign dout = din_d[DEPTH-1]; // last stage

endmodule

/* rtl/fcal_top.sv */
`timescale 1ns/1ns
`include "fcal_macros.svh"

module fcal_top (
	input logic clk_fb, // feedback clock, host side too
	input logic clk_refp, // accurate reference
	input logic rst,
	input fcal_pkg::axil_req_t axil_req,
	output fcal_pkg::axil_rsp_t axil_rsp
);

	import fcal_pkg::*;

	fcal_ctrl_t ctrl;
	logic clear;
	logic rst_ref; // rst in clk_refp domain
	logic ref_pulse;
	logic [`FCAL_SYNC_DEPTH-1:0] ref_pulse_d;
	fcal_cnt_t fcal_cnt;
	logic fcal_ready;
	fcal_stats_t stats;

	// ------------------------------
	// host side
	// ------------------------------
	fcal_axil_regs u_regs (
		.clk_fb(clk_fb),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.ctrl(ctrl),
		.clear(clear),
		.fcal_ready(fcal_ready),
		.stats(stats)
	);

	// ------------------------------
	// reference domain and crossing
	// ------------------------------
	fcal_sync #(.DEPTH(`FCAL_SYNC_DEPTH)) u_rst_sync (
		.clk(clk_refp),
		.din(rst),
		.dout(rst_ref),
		.din_d()
	);

	fcal_ref_pulse_gen u_pulse_gen (
		.clk_refp(clk_refp),
		.rst_ref(rst_ref),
		.ndiv(ctrl.ndiv),
		.ref_pulse(ref_pulse)
	);

	fcal_sync #(.DEPTH(`FCAL_SYNC_DEPTH)) u_pulse_sync (
		.clk(clk_fb),
		.din(ref_pulse),
		.dout(),
		.din_d(ref_pulse_d) // counter wants every stage
	);

	// measure and track
	fcal_counter u_counter (
		.clk_fb(clk_fb),
		.rst(rst),
		.ctrl(ctrl),
		.pulse_d(ref_pulse_d),
		.fcal_cnt(fcal_cnt),
		.fcal_ready(fcal_ready)
	);

	fcal_result_track u_track (
		.clk_fb(clk_fb),
		.rst(rst),
		.fcal_ready(fcal_ready),
		.fcal_cnt(fcal_cnt),
		.clear(clear),
		.stats(stats)
	);

endmodule
